// File: vread_defines.svh
`ifndef VREAD_DEFINES_SVH
`define VREAD_DEFINES_SVH

// external byte address width
`define VREAD_AXI_ADDR_W 32

// databus and scratch buffer word width
`define VREAD_WORD_W 32

// output symbol width, several symbols per word
`define VREAD_SYM_W 8

// buffer word address, top bit is the ping-pong half
`define VREAD_BUF_ADDR_W 9

// burst length field, holds words minus one
`define VREAD_LEN_W 8

// pattern period and duty
`define VREAD_PERIOD_W 7

// pattern start delay
`define VREAD_DELAY_W 6

`endif

// File: vread_pkg.sv
`default_nettype none

`include "vread_defines.svh"

package vread_pkg;

   // external memory side
   typedef logic [`VREAD_AXI_ADDR_W-1:0] ext_addr_t;
   typedef logic [`VREAD_WORD_W-1:0]     word_t;

   // one output symbol
   typedef logic [`VREAD_SYM_W-1:0] sym_t;

   // buffer word address, msb picks the half
   typedef logic [`VREAD_BUF_ADDR_W-1:0] buf_addr_t;

   // word address with the symbol select bits below it
   typedef logic [`VREAD_BUF_ADDR_W+$clog2(`VREAD_WORD_W/`VREAD_SYM_W)-1:0] sym_addr_t;

   // pattern and burst fields
   typedef logic [`VREAD_PERIOD_W-1:0] period_t;
   typedef logic [`VREAD_DELAY_W-1:0]  delay_t;
   typedef logic [`VREAD_LEN_W-1:0]    len_t;

endpackage

`default_nettype wire

// File: burst_reader.sv
`timescale 1ns/1ns
`default_nettype none

module burst_reader (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   input  wire vread_pkg::ext_addr_t start_addr_i,
   input  wire vread_pkg::ext_addr_t addr_shift_i,
   input  wire vread_pkg::buf_addr_t amount_i,
   input  wire vread_pkg::len_t      length_i,
   output logic                      databus_valid_o,
   output vread_pkg::ext_addr_t      databus_addr_o,
   output vread_pkg::len_t           databus_len_o,
   input  wire                       databus_ready_i,
   input  wire                       databus_last_i,
   output logic                      done_o
);

   localparam vread_pkg::ext_addr_t WORD_BYTES = $bits(vread_pkg::word_t) / 8;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_BURST
   } state_t;

   state_t               state;
   vread_pkg::buf_addr_t remaining;
   vread_pkg::buf_addr_t rem_sel;
   vread_pkg::buf_addr_t max_words;
   vread_pkg::buf_addr_t burst_words;
   logic                 beat;
   logic                 burst_end;

   assign databus_valid_o = (state == ST_BURST);
   assign beat            = databus_valid_o && databus_ready_i;
   assign burst_end       = beat && databus_last_i;

   // words left when the next burst starts; the final one gets trimmed
   assign rem_sel     = (state == ST_BURST) ? remaining - 1'b1 : remaining;
   assign max_words   = vread_pkg::buf_addr_t'(length_i) + 1'b1;
   assign burst_words = (rem_sel > max_words) ? max_words : rem_sel;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= ST_IDLE;
         remaining <= '0;
         done_o    <= 1'b1;
      end else if (run_i) begin
         remaining <= amount_i;
         if (amount_i != '0) begin
            state  <= ST_REQ;
            done_o <= 1'b0;
         end
      end else begin
         case (state)
            ST_REQ: begin
               state <= ST_BURST;
            end
            ST_BURST: begin
               if (beat) begin
                  remaining <= remaining - 1'b1;
               end
               // back-to-back bursts keep valid high
               if (burst_end && remaining == 1'b1) begin
                  state  <= ST_IDLE;
                  done_o <= 1'b1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // request fields
   always_ff @(posedge clk) begin
      if (run_i) begin
         databus_addr_o <= start_addr_i;
      end else if (burst_end) begin
         databus_addr_o <= databus_addr_o
                           + (vread_pkg::ext_addr_t'(databus_len_o) + 1'b1) * WORD_BYTES
                           + addr_shift_i;
      end
      if (state == ST_REQ || burst_end) begin
         databus_len_o <= vread_pkg::len_t'(burst_words - 1'b1);
      end
   end

   // request held steady until the beat marked last
   a_valid_held: assert property (@(posedge clk) disable iff (rst)
      databus_valid_o && !burst_end |=> databus_valid_o && $stable(databus_addr_o));

endmodule

`default_nettype wire

// File: handshake_join.sv
`timescale 1ns/1ns
`default_nettype none

module handshake_join #(
   parameter type first_t  = logic,
   parameter type second_t = logic
) (
   input  wire          clk,
   input  wire          rst,
   input  wire          flush_i,
   input  wire          first_valid_i,
   output logic         first_ready_o,
   input  wire first_t  first_data_i,
   input  wire          second_valid_i,
   output logic         second_ready_o,
   input  wire second_t second_data_i,
   output logic         result_valid_o,
   input  wire          result_ready_i,
   output first_t       result_first_o,
   output second_t      result_second_o
);

   logic    first_held;
   logic    second_held;
   first_t  first_q;
   second_t second_q;
   logic    fire;

   // a side that already waits takes nothing new
   assign first_ready_o  = !first_held;
   assign second_ready_o = !second_held;

   assign result_valid_o  = (first_held || first_valid_i) && (second_held || second_valid_i);
   assign result_first_o  = first_held ? first_q : first_data_i;
   assign result_second_o = second_held ? second_q : second_data_i;
   assign fire            = result_valid_o && result_ready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         first_held  <= 1'b0;
         second_held <= 1'b0;
      end else if (flush_i || fire) begin
         first_held  <= 1'b0;
         second_held <= 1'b0;
      end else begin
         if (first_valid_i && first_ready_o) begin
            first_held <= 1'b1;
         end
         if (second_valid_i && second_ready_o) begin
            second_held <= 1'b1;
         end
      end
   end

   // skid payloads
   always_ff @(posedge clk) begin
      if (first_valid_i && first_ready_o) begin
         first_q <= first_data_i;
      end
      if (second_valid_i && second_ready_o) begin
         second_q <= second_data_i;
      end
   end

   a_result_stable: assert property (@(posedge clk) disable iff (rst)
      result_valid_o && !result_ready_i && !flush_i
      |=> result_valid_o && $stable(result_first_o) && $stable(result_second_o));

endmodule

`default_nettype wire

// File: pattern_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_addr_gen (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   input  wire vread_pkg::delay_t    delay_i,
   input  wire vread_pkg::sym_addr_t start_i,
   input  wire vread_pkg::period_t   per_i,
   input  wire vread_pkg::period_t   duty_i,
   input  wire vread_pkg::buf_addr_t iter_i,
   input  wire vread_pkg::sym_addr_t incr_i,
   input  wire vread_pkg::sym_addr_t shift_i,
   output logic                      valid_o,
   output vread_pkg::sym_addr_t      addr_o,
   output logic                      done_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DELAY,
      ST_RUN
   } state_t;

   state_t               state;
   vread_pkg::delay_t    delay_cnt;
   vread_pkg::period_t   inner;
   vread_pkg::buf_addr_t outer;
   vread_pkg::sym_addr_t base;
   logic                 last_inner;
   logic                 last_outer;

   assign last_inner = (inner == per_i - 1'b1);
   assign last_outer = (outer == iter_i - 1'b1);

   // only the first duty cycles of each period read
   assign valid_o = (state == ST_RUN) && (inner < duty_i);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= ST_IDLE;
         delay_cnt <= '0;
         inner     <= '0;
         outer     <= '0;
         done_o    <= 1'b1;
      end else if (run_i) begin
         delay_cnt <= delay_i;
         inner     <= '0;
         outer     <= '0;
         done_o    <= 1'b0;
         if (delay_i != '0) begin
            state <= ST_DELAY;
         end else if (iter_i != '0) begin
            state <= ST_RUN;
         end else begin
            // nothing to read at all
            state  <= ST_IDLE;
            done_o <= 1'b1;
         end
      end else begin
         case (state)
            ST_DELAY: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == 1'b1) begin
                  if (iter_i != '0) begin
                     state <= ST_RUN;
                  end else begin
                     state  <= ST_IDLE;
                     done_o <= 1'b1;
                  end
               end
            end
            ST_RUN: begin
               if (last_inner) begin
                  inner <= '0;
                  outer <= outer + 1'b1;
                  if (last_outer) begin
                     state  <= ST_IDLE;
                     done_o <= 1'b1;
                  end
               end else begin
                  inner <= inner + 1'b1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // base moves by shift per period, addr by incr within it
   always_ff @(posedge clk) begin
      if (run_i) begin
         base   <= start_i;
         addr_o <= start_i;
      end else if (state == ST_RUN) begin
         if (last_inner) begin
            base   <= base + shift_i;
            addr_o <= base + shift_i;
         end else begin
            addr_o <= addr_o + incr_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: scratch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module scratch_buffer (
   input  wire                       clk,
   input  wire                       wr_en_i,
   input  wire vread_pkg::buf_addr_t wr_addr_i,
   input  wire vread_pkg::word_t     wr_data_i,
   input  wire                       rd_en_i,
   input  wire vread_pkg::buf_addr_t rd_addr_i,
   output vread_pkg::word_t          rd_data_o
);

   localparam int DEPTH = 1 << $bits(vread_pkg::buf_addr_t);

   // both halves in one array
   vread_pkg::word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read data one cycle after the address
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: vread_unit.sv
`timescale 1ns/1ns
`default_nettype none

module vread_unit (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   output logic                      done_o,
   output logic                      databus_valid_o,
   output vread_pkg::ext_addr_t      databus_addr_o,
   output vread_pkg::len_t           databus_len_o,
   input  wire                       databus_ready_i,
   input  wire vread_pkg::word_t     databus_rdata_i,
   input  wire                       databus_last_i,
   input  wire vread_pkg::ext_addr_t ext_addr_i,
   input  wire vread_pkg::ext_addr_t addr_shift_i,
   input  wire vread_pkg::buf_addr_t amount_i,
   input  wire vread_pkg::len_t      length_i,
   input  wire                       pingpong_i,
   input  wire vread_pkg::delay_t    delay_i,
   input  wire vread_pkg::sym_addr_t start_i,
   input  wire vread_pkg::period_t   per_i,
   input  wire vread_pkg::period_t   duty_i,
   input  wire vread_pkg::buf_addr_t iter_i,
   input  wire vread_pkg::sym_addr_t incr_i,
   input  wire vread_pkg::sym_addr_t shift_i,
   output logic                      buf_wr_en_o,
   output vread_pkg::buf_addr_t      buf_wr_addr_o,
   output vread_pkg::word_t          buf_wr_data_o,
   output logic                      buf_rd_en_o,
   output vread_pkg::buf_addr_t      buf_rd_addr_o,
   input  wire vread_pkg::word_t     buf_rd_data_i,
   output logic                      out_valid_o,
   output vread_pkg::sym_t           out_o
);

   localparam int BUF_W = $bits(vread_pkg::buf_addr_t);
   localparam int SEL_W = $bits(vread_pkg::sym_addr_t) - BUF_W;
   localparam int SYM_W = $bits(vread_pkg::sym_t);

   logic                 run;
   logic                 pp_state;
   logic                 load_done;
   logic                 pat_done;
   logic                 pat_valid;
   vread_pkg::sym_addr_t pat_addr;
   vread_pkg::buf_addr_t pat_word;
   vread_pkg::buf_addr_t wr_cnt;
   vread_pkg::buf_addr_t wr_addr;
   logic                 wr_addr_valid;
   logic                 wr_addr_ready;
   logic                 beat_valid;
   logic                 beat_ready;
   logic                 rd_valid_q;
   logic [SEL_W-1:0]     sel_q;

   // run only counts while idle
   assign run = run_i && done_o;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_o <= 1'b1;
      end else if (run) begin
         done_o <= 1'b0;
      end else if (load_done && pat_done) begin
         done_o <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run) begin
         pp_state <= pingpong_i ? !pp_state : 1'b0;
      end
   end

   burst_reader u_reader (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run),
      .start_addr_i    (ext_addr_i),
      .addr_shift_i    (addr_shift_i),
      .amount_i        (amount_i),
      .length_i        (length_i),
      .databus_valid_o (databus_valid_o),
      .databus_addr_o  (databus_addr_o),
      .databus_len_o   (databus_len_o),
      .databus_ready_i (databus_ready_i),
      .databus_last_i  (databus_last_i),
      .done_o          (load_done)
   );

   // write addresses, one per loaded word; load goes to the other half
   assign wr_addr_valid = !load_done && (wr_cnt != amount_i);
   assign wr_addr       = {pingpong_i ? !pp_state : wr_cnt[BUF_W-1], wr_cnt[BUF_W-2:0]};
   assign beat_valid    = databus_valid_o && databus_ready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_cnt <= '0;
      end else if (run) begin
         wr_cnt <= '0;
      end else if (wr_addr_valid && wr_addr_ready) begin
         wr_cnt <= wr_cnt + 1'b1;
      end
   end

   handshake_join #(
      .first_t  (vread_pkg::buf_addr_t),
      .second_t (vread_pkg::word_t)
   ) u_join (
      .clk             (clk),
      .rst             (rst),
      .flush_i         (run),
      .first_valid_i   (wr_addr_valid),
      .first_ready_o   (wr_addr_ready),
      .first_data_i    (wr_addr),
      .second_valid_i  (beat_valid),
      .second_ready_o  (beat_ready),
      .second_data_i   (databus_rdata_i),
      .result_valid_o  (buf_wr_en_o),
      .result_ready_i  (1'b1),
      .result_first_o  (buf_wr_addr_o),
      .result_second_o (buf_wr_data_o)
   );

   pattern_addr_gen u_pattern (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run),
      .delay_i (delay_i),
      .start_i (start_i),
      .per_i   (per_i),
      .duty_i  (duty_i),
      .iter_i  (iter_i),
      .incr_i  (incr_i),
      .shift_i (shift_i),
      .valid_o (pat_valid),
      .addr_o  (pat_addr),
      .done_o  (pat_done)
   );

   // output reads the current half
   assign pat_word      = pat_addr[SEL_W +: BUF_W];
   assign buf_rd_en_o   = pat_valid;
   assign buf_rd_addr_o = {pingpong_i ? pp_state : pat_word[BUF_W-1], pat_word[BUF_W-2:0]};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_valid_q  <= 1'b0;
         out_valid_o <= 1'b0;
      end else begin
         rd_valid_q  <= pat_valid;
         out_valid_o <= rd_valid_q;
      end
   end

   // select travels with the buffer read, then picks the symbol
   always_ff @(posedge clk) begin
      if (pat_valid) begin
         sel_q <= pat_addr[SEL_W-1:0];
      end
      if (rd_valid_q) begin
         out_o <= buf_rd_data_i[sel_q*SYM_W +: SYM_W];
      end
   end

   // load and output must stay inside their own half
   a_wr_in_half: assert property (@(posedge clk) disable iff (rst)
      pingpong_i && wr_addr_valid |-> !wr_cnt[BUF_W-1]);

   a_rd_in_half: assert property (@(posedge clk) disable iff (rst)
      pingpong_i && pat_valid |-> !pat_addr[$bits(vread_pkg::sym_addr_t)-1]);

   // every databus beat lands in the buffer the same cycle
   a_no_stall: assert property (@(posedge clk) disable iff (rst)
      beat_valid |-> beat_ready && buf_wr_en_o);

endmodule

`default_nettype wire

// File: vread_top.sv
`timescale 1ns/1ns
`default_nettype none

module vread_top (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   output logic                      done_o,
   output logic                      databus_valid_o,
   output vread_pkg::ext_addr_t      databus_addr_o,
   output vread_pkg::len_t           databus_len_o,
   input  wire                       databus_ready_i,
   input  wire vread_pkg::word_t     databus_rdata_i,
   input  wire                       databus_last_i,
   input  wire vread_pkg::ext_addr_t ext_addr_i,
   input  wire vread_pkg::ext_addr_t addr_shift_i,
   input  wire vread_pkg::buf_addr_t amount_i,
   input  wire vread_pkg::len_t      length_i,
   input  wire                       pingpong_i,
   input  wire vread_pkg::delay_t    delay_i,
   input  wire vread_pkg::sym_addr_t start_i,
   input  wire vread_pkg::period_t   per_i,
   input  wire vread_pkg::period_t   duty_i,
   input  wire vread_pkg::buf_addr_t iter_i,
   input  wire vread_pkg::sym_addr_t incr_i,
   input  wire vread_pkg::sym_addr_t shift_i,
   output logic                      out_valid_o,
   output vread_pkg::sym_t           out_o
);

   // scratch buffer ports
   logic                 buf_wr_en;
   vread_pkg::buf_addr_t buf_wr_addr;
   vread_pkg::word_t     buf_wr_data;
   logic                 buf_rd_en;
   vread_pkg::buf_addr_t buf_rd_addr;
   vread_pkg::word_t     buf_rd_data;

   vread_unit u_unit (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .done_o          (done_o),
      .databus_valid_o (databus_valid_o),
      .databus_addr_o  (databus_addr_o),
      .databus_len_o   (databus_len_o),
      .databus_ready_i (databus_ready_i),
      .databus_rdata_i (databus_rdata_i),
      .databus_last_i  (databus_last_i),
      .ext_addr_i      (ext_addr_i),
      .addr_shift_i    (addr_shift_i),
      .amount_i        (amount_i),
      .length_i        (length_i),
      .pingpong_i      (pingpong_i),
      .delay_i         (delay_i),
      .start_i         (start_i),
      .per_i           (per_i),
      .duty_i          (duty_i),
      .iter_i          (iter_i),
      .incr_i          (incr_i),
      .shift_i         (shift_i),
      .buf_wr_en_o     (buf_wr_en),
      .buf_wr_addr_o   (buf_wr_addr),
      .buf_wr_data_o   (buf_wr_data),
      .buf_rd_en_o     (buf_rd_en),
      .buf_rd_addr_o   (buf_rd_addr),
      .buf_rd_data_i   (buf_rd_data),
      .out_valid_o     (out_valid_o),
      .out_o           (out_o)
   );

   scratch_buffer u_buffer (
      .clk       (clk),
      .wr_en_i   (buf_wr_en),
      .wr_addr_i (buf_wr_addr),
      .wr_data_i (buf_wr_data),
      .rd_en_i   (buf_rd_en),
      .rd_addr_i (buf_rd_addr),
      .rd_data_o (buf_rd_data)
   );

endmodule

`default_nettype wire

// File: tb_bus_memory.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bus_memory #(
   parameter int SEED = 32'h5712
) (
   input  wire                       clk,
   input  wire                       databus_valid_i,
   input  wire vread_pkg::ext_addr_t databus_addr_i,
   input  wire vread_pkg::len_t      databus_len_i,
   output logic                      databus_ready_o,
   output vread_pkg::word_t          databus_rdata_o,
   output logic                      databus_last_o
);

   integer          seed;
   vread_pkg::len_t beat_cnt;
   logic            gap_q;

   // memory contents, a mix of every address bit
   function automatic vread_pkg::word_t fill_word(input vread_pkg::ext_addr_t addr);
      fill_word = (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
   endfunction

   initial begin
      seed            = SEED;
      beat_cnt        = '0;
      gap_q           = 1'b0;
      databus_ready_o = 1'b0;
      databus_rdata_o = '0;
      databus_last_o  = 1'b0;
   end

   always @(negedge clk) begin
      // a beat offered last cycle was taken at the edge just passed
      if (databus_ready_o) begin
         if (databus_last_o) begin
            beat_cnt = '0;
         end else begin
            beat_cnt = beat_cnt + 1'b1;
         end
      end
      if (databus_valid_i) begin
         // never two idle cycles in a row
         databus_ready_o = gap_q || (($random(seed) & 3) != 0);
         gap_q           = !databus_ready_o;
         databus_rdata_o = fill_word(databus_addr_i + 4 * beat_cnt);
         databus_last_o  = (beat_cnt == databus_len_i);
      end else begin
         databus_ready_o = 1'b0;
         databus_last_o  = 1'b0;
         gap_q           = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: tb_vread.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vread;

   localparam int NUM_RUNS    = 20;
   localparam int CYCLE_LIMIT = NUM_RUNS * (256 * 4 + 8 * 16 + 63 + 200);
   localparam int BUF_W       = $bits(vread_pkg::buf_addr_t);
   localparam int SEL_W       = $bits(vread_pkg::sym_addr_t) - BUF_W;
   localparam int SYM_W       = $bits(vread_pkg::sym_t);

   logic                 clk;
   logic                 rst;
   logic                 run;
   logic                 pingpong;
   logic                 done;
   logic                 bus_valid;
   logic                 bus_ready;
   logic                 bus_last;
   logic                 out_valid;
   vread_pkg::ext_addr_t ext_addr;
   vread_pkg::ext_addr_t addr_shift;
   vread_pkg::ext_addr_t bus_addr;
   vread_pkg::buf_addr_t amount;
   vread_pkg::buf_addr_t iter;
   vread_pkg::len_t      length;
   vread_pkg::len_t      bus_len;
   vread_pkg::delay_t    delay;
   vread_pkg::sym_addr_t start;
   vread_pkg::sym_addr_t incr;
   vread_pkg::sym_addr_t shift;
   vread_pkg::period_t   per;
   vread_pkg::period_t   duty;
   vread_pkg::word_t     bus_rdata;
   vread_pkg::sym_t      out_sym;

   integer seed;
   int     cycles = 0;
   int     beat_count;
   int     out_count;
   logic   in_burst = 1'b0;
   logic   pp_model = 1'b0;

   // reference copy of both buffer halves
   vread_pkg::word_t     model_buf [1 << BUF_W];
   vread_pkg::sym_t      exp_sym_q [$];
   vread_pkg::ext_addr_t req_addr_q [$];
   vread_pkg::len_t      req_len_q [$];
   vread_pkg::buf_addr_t load_idx_q [$];
   vread_pkg::word_t     load_word_q [$];

   vread_top dut0 (
      .clk (clk), .rst (rst), .run_i (run), .done_o (done),
      .databus_valid_o (bus_valid), .databus_addr_o (bus_addr), .databus_len_o (bus_len),
      .databus_ready_i (bus_ready), .databus_rdata_i (bus_rdata), .databus_last_i (bus_last),
      .ext_addr_i (ext_addr), .addr_shift_i (addr_shift), .amount_i (amount),
      .length_i (length), .pingpong_i (pingpong), .delay_i (delay), .start_i (start),
      .per_i (per), .duty_i (duty), .iter_i (iter), .incr_i (incr), .shift_i (shift),
      .out_valid_o (out_valid), .out_o (out_sym)
   );

   tb_bus_memory #(.SEED(32'h5712)) u_mem (
      .clk (clk), .databus_valid_i (bus_valid), .databus_addr_i (bus_addr),
      .databus_len_i (bus_len), .databus_ready_o (bus_ready),
      .databus_rdata_o (bus_rdata), .databus_last_o (bus_last)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_sym(input string name, input vread_pkg::sym_t got,
                            input vread_pkg::sym_t exp);
      if (got !== exp) report_failure($sformatf("Mismatch %s got %0h expected %0h", name, got, exp));
   endtask

   task automatic check_addr(input string name, input vread_pkg::ext_addr_t got,
                             input vread_pkg::ext_addr_t exp);
      if (got !== exp) report_failure($sformatf("Mismatch %s got %0h expected %0h", name, got, exp));
   endtask

   task automatic check_word(input string name, input vread_pkg::word_t got,
                             input vread_pkg::word_t exp);
      if (got !== exp) report_failure($sformatf("Mismatch %s got %0h expected %0h", name, got, exp));
   endtask

   task automatic check_len(input string name, input vread_pkg::len_t got,
                            input vread_pkg::len_t exp);
      if (got !== exp) report_failure($sformatf("Mismatch %s got %0h expected %0h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) report_failure($sformatf("Mismatch %s got %0h expected %0h", name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) report_failure($sformatf("Mismatch %s got %0h expected %0h", name, got, exp));
   endtask

   function automatic int pick(input int lo, input int hi);
      pick = lo + ({$random(seed)} % (hi - lo + 1));
   endfunction

   // same fill as the memory model
   function automatic vread_pkg::word_t fill_word(input vread_pkg::ext_addr_t addr);
      fill_word = (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
   endfunction

   task automatic pick_config(input int r);
      if (r < 2) begin
         // first two runs fill both halves and read nothing
         pingpong = 1'b1;
         amount   = vread_pkg::buf_addr_t'(256);
         delay    = '0;
         iter     = '0;
      end else if (r % 4 == 3) begin
         // short load into half 0 with reads starting after it
         pingpong = 1'b0;
         amount   = vread_pkg::buf_addr_t'(pick(1, 12));
         delay    = vread_pkg::delay_t'(63);
         iter     = vread_pkg::buf_addr_t'(pick(1, 8));
      end else begin
         pingpong = 1'b1;
         amount   = vread_pkg::buf_addr_t'(pick(1, 256));
         delay    = vread_pkg::delay_t'(pick(0, 20));
         iter     = vread_pkg::buf_addr_t'(pick(1, 8));
      end
      ext_addr   = vread_pkg::ext_addr_t'({$random(seed)} & 32'h00ff_fffc);
      addr_shift = vread_pkg::ext_addr_t'(pick(0, 64));
      length     = vread_pkg::len_t'(pick(0, 40));
      per        = vread_pkg::period_t'(pick(2, 16));
      duty       = vread_pkg::period_t'(pick(1, int'(per) - 1));
      start      = vread_pkg::sym_addr_t'(pick(0, 255));
      incr       = vread_pkg::sym_addr_t'(pick(0, 7));
      shift      = vread_pkg::sym_addr_t'(pick(0, 31));
   endtask

   // bursts, loaded words and output symbols of one run
   task automatic build_expected();
      vread_pkg::ext_addr_t a;
      vread_pkg::buf_addr_t idx;
      vread_pkg::sym_addr_t s;
      vread_pkg::word_t     w;
      int                   left;
      int                   n;
      int                   cnt;
      load_idx_q.delete();
      load_word_q.delete();
      beat_count = 0;
      out_count  = 0;
      pp_model   = pingpong ? !pp_model : 1'b0;
      a    = ext_addr;
      left = amount;
      cnt  = 0;
      while (left > 0) begin
         n = (left < int'(length) + 1) ? left : int'(length) + 1;
         req_addr_q.push_back(a);
         req_len_q.push_back(vread_pkg::len_t'(n - 1));
         for (int b = 0; b < n; b++) begin
            idx = vread_pkg::buf_addr_t'(cnt);
            if (pingpong) idx[BUF_W-1] = !pp_model;
            w = fill_word(a + 4 * b);
            model_buf[idx] = w;
            load_idx_q.push_back(idx);
            load_word_q.push_back(w);
            cnt++;
         end
         a    = a + 4 * n + addr_shift;
         left = left - n;
      end
      for (int j = 0; j < int'(iter); j++) begin
         for (int k = 0; k < int'(duty); k++) begin
            s   = start + k * incr + j * shift;
            idx = s[SEL_W +: BUF_W];
            if (pingpong) idx[BUF_W-1] = pp_model;
            exp_sym_q.push_back(vread_pkg::sym_t'(model_buf[idx] >> (s[SEL_W-1:0] * SYM_W)));
         end
      end
   endtask

   task automatic check_buffer();
      for (int i = 0; i < load_idx_q.size(); i++) begin
         check_word($sformatf("mem[%0h]", load_idx_q[i]), dut0.u_buffer.mem[load_idx_q[i]],
                    load_word_q[i]);
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         report_failure($sformatf("timeout after %0d cycles, a run never finished", cycles));
      end
   end

   // output symbols and databus requests sampled before the edge updates them
   always @(posedge clk) begin
      if (!rst) begin
         if (out_valid) begin
            out_count++;
            if (exp_sym_q.size() == 0) report_failure("output symbol arrived with none expected");
            else check_sym("out_o", out_sym, exp_sym_q.pop_front());
         end
         if (bus_valid && !in_burst) begin
            in_burst = 1'b1;
            if (req_addr_q.size() == 0) report_failure("databus request arrived with none expected");
            else begin
               check_addr("databus_addr_o", bus_addr, req_addr_q.pop_front());
               check_len("databus_len_o", bus_len, req_len_q.pop_front());
            end
         end
         if (bus_valid && bus_ready) begin
            beat_count++;
            if (bus_last) in_burst = 1'b0;
         end
      end
   end

   initial begin
      seed     = 32'h5712;
      rst      = 1'b1;
      run      = 1'b0;
      pick_config(0);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_bit("done_o", done, 1'b1);
      check_bit("databus_valid_o", bus_valid, 1'b0);
      check_bit("out_valid_o", out_valid, 1'b0);
      for (int r = 0; r < NUM_RUNS; r++) begin
         pick_config(r);
         build_expected();
         @(negedge clk);
         run = 1'b1;
         @(negedge clk);
         run = 1'b0;
         check_bit("done_o", done, 1'b0);
         while (done !== 1'b1) @(negedge clk);
         // done only after the last beat
         check_count("databus beats", beat_count, int'(amount));
         // output trails the pattern by two cycles
         repeat (3) @(negedge clk);
         check_count("out_valid_o cycles", out_count, int'(iter) * int'(duty));
         if (exp_sym_q.size() != 0 || req_addr_q.size() != 0) begin
            report_failure("run ended with expected symbols or bursts still missing");
         end
         check_buffer();
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vread.f
+incdir+.
vread_pkg.sv
burst_reader.sv
handshake_join.sv
pattern_addr_gen.sv
scratch_buffer.sv
vread_unit.sv
vread_top.sv
tb_bus_memory.sv
tb_vread.sv
